// File: Makefile
VERILATOR ?= verilator
TOP       ?= pipeControlTb
FILELIST  ?= pipeControl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

PASS_MSG := PASS: all tests
SOURCES  := $(shell grep -v '^+' $(FILELIST))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/hazardDetect.sv
`timescale 1ns/1ps

module hazardDetect (
    input  hazardPkg::decodeInstT decodeInst,
    input  hazardPkg::loadSlotT   exeSlot,
    input  hazardPkg::loadSlotT   memSlot,
    input  hazardPkg::loadSlotT   mem2Slot,
    output hazardPkg::hazardT     hazard
);

    // Load in a later stage writes a register that decode reads
    function automatic logic loadUse(
        input hazardPkg::decodeInstT inst,
        input hazardPkg::loadSlotT   slot
    );
        logic srcMatch;
        srcMatch = (slot.dest == inst.rs) || (slot.dest == inst.rt);
        return inst.valid && slot.valid && slot.isLoad
               && (slot.dest != '0) && srcMatch;  // $zero never carries data
    endfunction

    always_comb begin
        hazard.exStall   = loadUse(decodeInst, exeSlot);
        hazard.mem1Stall = loadUse(decodeInst, memSlot);
        hazard.mem2Stall = loadUse(decodeInst, mem2Slot);

        // A bubble in decode must never hold the front end
        if (!decodeInst.valid) begin
            assert (hazard == '0)
                else $error("hazardDetect: stall %b with invalid decode", hazard);
        end
    end

endmodule

// File: hdl/hazardPkg.sv
package hazardPkg;

    localparam int REG_W = 5;

    // Instruction currently in decode
    typedef struct packed {
        logic             valid;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [REG_W-1:0] dest;
        logic             isLoad;
    } decodeInstT;

    // Back-end slot as seen by the load-use check
    typedef struct packed {
        logic             valid;
        logic [REG_W-1:0] dest;
        logic             isLoad;
    } loadSlotT;

    // Writeback only needs the destination
    typedef struct packed {
        logic             valid;
        logic [REG_W-1:0] dest;
    } retireSlotT;

    typedef struct packed {
        logic exStall;
        logic mem1Stall;
        logic mem2Stall;
    } hazardT;

endpackage

// File: hdl/occupancyTrack.sv
`timescale 1ns/1ps

module occupancyTrack (
    input  logic                  clk,
    input  logic                  reset,
    input  pipeCtrlPkg::ctrlWordT ctrl,
    input  hazardPkg::decodeInstT decodeInst,
    output hazardPkg::loadSlotT   exeSlot,
    output hazardPkg::loadSlotT   memSlot,
    output hazardPkg::loadSlotT   mem2Slot,
    output hazardPkg::retireSlotT wbSlot
);

    hazardPkg::loadSlotT   exeIn;
    hazardPkg::retireSlotT wbIn;

    // Only the destination and load flag travel past decode
    assign exeIn = hazardPkg::loadSlotT'{
        valid:  decodeInst.valid,
        dest:   decodeInst.dest,
        isLoad: decodeInst.isLoad
    };
    assign wbIn = hazardPkg::retireSlotT'{valid: mem2Slot.valid, dest: mem2Slot.dest};

    stageSlot #(.slotT(hazardPkg::loadSlotT)) exeStage_i (
        .clk   (clk),
        .reset (reset),
        .wr    (ctrl.wr[pipeCtrlPkg::stExe]),
        .flush (ctrl.flush[pipeCtrlPkg::stExe]),
        .prev  (exeIn),
        .cur   (exeSlot)
    );

    stageSlot #(.slotT(hazardPkg::loadSlotT)) memStage_i (
        .clk   (clk),
        .reset (reset),
        .wr    (ctrl.wr[pipeCtrlPkg::stMem]),
        .flush (ctrl.flush[pipeCtrlPkg::stMem]),
        .prev  (exeSlot),
        .cur   (memSlot)
    );

    stageSlot #(.slotT(hazardPkg::loadSlotT)) mem2Stage_i (
        .clk   (clk),
        .reset (reset),
        .wr    (ctrl.wr[pipeCtrlPkg::stMem2]),
        .flush (ctrl.flush[pipeCtrlPkg::stMem2]),
        .prev  (memSlot),
        .cur   (mem2Slot)
    );

    stageSlot #(.slotT(hazardPkg::retireSlotT)) wbStage_i (
        .clk   (clk),
        .reset (reset),
        .wr    (ctrl.wr[pipeCtrlPkg::stWb]),
        .flush (ctrl.flush[pipeCtrlPkg::stWb]),
        .prev  (wbIn),
        .cur   (wbSlot)
    );

endmodule

// File: hdl/pipeControlTop.sv
`timescale 1ns/1ps

module pipeControlTop (
    input  logic                  clk,
    input  logic                  reset,
    input  pipeCtrlPkg::stallInT  events,
    input  hazardPkg::decodeInstT decodeInst,
    output pipeCtrlPkg::ctrlWordT ctrl,
    output hazardPkg::loadSlotT   exeSlot,
    output hazardPkg::loadSlotT   memSlot,
    output hazardPkg::loadSlotT   mem2Slot,
    output hazardPkg::retireSlotT wbSlot
);

    hazardPkg::hazardT hazard;  // Load-use stalls for this cycle

    hazardDetect hazardDetect_i (
        .decodeInst (decodeInst),
        .exeSlot    (exeSlot),
        .memSlot    (memSlot),
        .mem2Slot   (mem2Slot),
        .hazard     (hazard)
    );

    pipelineControl pipelineControl_i (
        .events (events),
        .hazard (hazard),
        .ctrl   (ctrl)
    );

    // Slots follow the same wr/flush the datapath sees
    occupancyTrack occupancyTrack_i (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .decodeInst (decodeInst),
        .exeSlot    (exeSlot),
        .memSlot    (memSlot),
        .mem2Slot   (mem2Slot),
        .wbSlot     (wbSlot)
    );

endmodule

// File: hdl/pipeCtrlPkg.sv
package pipeCtrlPkg;

    localparam int NUM_STAGES = 7;

    // Stage order matches the bit order of wr and flush
    typedef enum logic [2:0] {
        stPreIf,
        stIf,
        stId,
        stExe,
        stMem,
        stMem2,
        stWb
    } stageE;

    // Event inputs from caches, TLBs, mult/div and branch unit
    typedef struct packed {
        logic dTlbStall;
        logic iTlbStall;
        logic dCacheBusy;
        logic iCacheBusy;
        logic multDivBusy;
        logic exceptionFlush;
        logic predictFailed;
        logic flushAll;       // Mispredict that also drops exe
        logic isBranchLikely;
        logic isTaken;
    } stallInT;

    typedef struct packed {
        logic id;
        logic exe;   // HI/LO write kill
        logic mem;   // CP0 write kill
        logic wb;
    } disWrT;

    typedef struct packed {
        logic [NUM_STAGES-1:0] wr;     // Indexed by stageE
        logic [NUM_STAGES-1:1] flush;  // No flush for preIf
        disWrT                 disWr;
        logic                  iReqValid;
        logic                  dReqValid;
        logic                  iCacheStall;
        logic                  dCacheStall;
    } ctrlWordT;

endpackage

// File: hdl/pipelineControl.sv
`timescale 1ns/1ps

module pipelineControl (
    input  pipeCtrlPkg::stallInT  events,
    input  hazardPkg::hazardT     hazard,
    output pipeCtrlPkg::ctrlWordT ctrl
);

    logic memSideStall;
    logic busStall;       // Cache, TLB or mult/div holds everything
    logic anyHazard;
    logic brLikelyFlush;  // Taken branch-likely kills its delay slot
    logic allMoving;

    assign memSideStall  = events.dTlbStall || events.dCacheBusy;
    assign busStall      = memSideStall || events.iTlbStall || events.iCacheBusy
                           || events.multDivBusy;
    assign anyHazard     = hazard.exStall || hazard.mem1Stall || hazard.mem2Stall;
    assign brLikelyFlush = events.isBranchLikely && events.isTaken;

    always_comb begin
        ctrl = '0;

        if (busStall) begin
            ctrl.disWr.mem   = 1'b1;
            ctrl.disWr.wb    = 1'b1;
            ctrl.iCacheStall = 1'b1;
            ctrl.dCacheStall = 1'b1;
        end else if (events.exceptionFlush) begin
            ctrl.wr[pipeCtrlPkg::stPreIf] = 1'b1;
            ctrl.wr[pipeCtrlPkg::stMem2]  = 1'b1;
            ctrl.wr[pipeCtrlPkg::stWb]    = 1'b1;
            ctrl.flush[pipeCtrlPkg::stMem:pipeCtrlPkg::stIf] = '1;  // Kill if..mem
            ctrl.disWr.mem = 1'b1;
        end else if (events.flushAll) begin
            ctrl.wr[pipeCtrlPkg::stPreIf] = 1'b1;
            ctrl.wr[pipeCtrlPkg::stWb:pipeCtrlPkg::stExe] = '1;
            ctrl.flush[pipeCtrlPkg::stExe:pipeCtrlPkg::stIf] = '1;
        end else if (hazard.mem2Stall) begin
            ctrl.wr[pipeCtrlPkg::stMem2]    = 1'b1;
            ctrl.wr[pipeCtrlPkg::stWb]      = 1'b1;
            ctrl.flush[pipeCtrlPkg::stMem2] = 1'b1;  // Bubble into mem2
            ctrl.disWr.mem   = 1'b1;
            ctrl.iCacheStall = 1'b1;
        end else if (hazard.mem1Stall) begin
            ctrl.wr[pipeCtrlPkg::stWb:pipeCtrlPkg::stMem] = '1;
            ctrl.flush[pipeCtrlPkg::stMem] = 1'b1;
            ctrl.iCacheStall = 1'b1;
        end else if (hazard.exStall) begin
            ctrl.wr[pipeCtrlPkg::stWb:pipeCtrlPkg::stExe] = '1;
            ctrl.flush[pipeCtrlPkg::stExe] = 1'b1;
            ctrl.disWr.id    = 1'b1;
            ctrl.iCacheStall = 1'b1;
        end else if (events.predictFailed) begin
            ctrl.wr[pipeCtrlPkg::stPreIf] = 1'b1;
            ctrl.wr[pipeCtrlPkg::stWb:pipeCtrlPkg::stExe] = '1;
            ctrl.flush[pipeCtrlPkg::stIf]  = 1'b1;
            ctrl.flush[pipeCtrlPkg::stId]  = 1'b1;
            ctrl.flush[pipeCtrlPkg::stExe] = brLikelyFlush;
        end else begin
            ctrl.wr = '1;
            ctrl.flush[pipeCtrlPkg::stExe] = brLikelyFlush;
        end

        // exe write-disable has an order of its own
        if (events.exceptionFlush) begin
            ctrl.disWr.exe = 1'b1;
        end else if (events.flushAll) begin
            ctrl.disWr.exe = 1'b0;
        end else begin
            ctrl.disWr.exe = hazard.mem1Stall || events.multDivBusy;
        end

        ctrl.iReqValid = !(events.exceptionFlush || anyHazard
                           || events.predictFailed || events.flushAll);
        ctrl.dReqValid = !events.exceptionFlush;

        // The D side only ever stalls together with the I side
        assert (!ctrl.dCacheStall || ctrl.iCacheStall)
            else $error("pipelineControl: dCacheStall without iCacheStall");
    end

    // Every stage either advances or is emptied
    assign allMoving = ctrl.wr[pipeCtrlPkg::stPreIf]
                       && (&(ctrl.wr[pipeCtrlPkg::NUM_STAGES-1:1] | ctrl.flush));

    always_comb begin
        if (!busStall && !anyHazard && !events.predictFailed && !events.exceptionFlush) begin
            assert (allMoving)
                else $error("pipelineControl: stage frozen with no stall cause");
        end
    end

endmodule

// File: hdl/stageSlot.sv
`timescale 1ns/1ps

module stageSlot #(
    parameter type slotT = logic
) (
    input  logic clk,
    input  logic reset,
    input  logic wr,
    input  logic flush,
    input  slotT prev,
    output slotT cur
);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            cur <= '0;       // Empty slot
        end else if (wr) begin
            cur <= prev;
        end                  // Otherwise hold through the stall
    end

    // Downstream hazard checks rely on a defined slot
    slotKnown: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(cur)
    ) else $error("stageSlot: unknown contents after reset");

endmodule

// File: pipeControl.f
hdl/pipeCtrlPkg.sv
hdl/hazardPkg.sv
hdl/hazardDetect.sv
hdl/pipelineControl.sv
hdl/stageSlot.sv
hdl/occupancyTrack.sv
hdl/pipeControlTop.sv
sim/pipeControlTb.sv

// File: sim/pipeControlTb.sv
`timescale 1ns/1ps

module pipeControlTb;

    localparam int    resetCycles = 8;
    localparam int    maxLines    = 256;    // Bound on the vector read loop
    localparam int    watchdogNs  = 20000;
    localparam string vecFile     = "sim/pipeControl_vectors.txt";

    logic                  clk;
    logic                  reset;
    pipeCtrlPkg::stallInT  events;
    hazardPkg::decodeInstT decodeInst;
    pipeCtrlPkg::ctrlWordT ctrl;
    hazardPkg::loadSlotT   exeSlot;
    hazardPkg::loadSlotT   memSlot;
    hazardPkg::loadSlotT   mem2Slot;
    hazardPkg::retireSlotT wbSlot;

    // Reference copy of the back-end stages
    hazardPkg::loadSlotT   mExe;
    hazardPkg::loadSlotT   mMem;
    hazardPkg::loadSlotT   mMem2;
    hazardPkg::retireSlotT mWb;
    pipeCtrlPkg::ctrlWordT prevCtrl;  // Word in effect until the next edge
    hazardPkg::decodeInstT prevDec;

    int ctrlErrors;
    int slotErrors;
    int hazardErrors;
    int otherErrors;
    int vectorCount;

    pipeControlTop pipeControlTop_i (
        .clk        (clk),
        .reset      (reset),
        .events     (events),
        .decodeInst (decodeInst),
        .ctrl       (ctrl),
        .exeSlot    (exeSlot),
        .memSlot    (memSlot),
        .mem2Slot   (mem2Slot),
        .wbSlot     (wbSlot)
    );

    always #5 clk = ~clk;

    task automatic checkCtrl(input string name, input pipeCtrlPkg::ctrlWordT got,
                             input pipeCtrlPkg::ctrlWordT exp);
        if (got !== exp) begin
            ctrlErrors++;
            $display("CHECK FAILED time=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkLoadSlot(input string name, input hazardPkg::loadSlotT got,
                                 input hazardPkg::loadSlotT exp);
        if (got !== exp) begin
            slotErrors++;
            $display("CHECK FAILED time=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkRetire(input string name, input hazardPkg::retireSlotT got,
                               input hazardPkg::retireSlotT exp);
        if (got !== exp) begin
            slotErrors++;
            $display("CHECK FAILED time=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkHazard(input string name, input hazardPkg::hazardT got,
                               input hazardPkg::hazardT exp);
        if (got !== exp) begin
            hazardErrors++;
            $display("CHECK FAILED time=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Load in slot s feeds a source of decode instruction d
    function automatic logic stallsOn(input hazardPkg::decodeInstT d,
                                      input hazardPkg::loadSlotT s);
        logic hit;
        hit = 1'b0;
        if (d.valid && s.valid && s.isLoad && s.dest != 5'd0) begin
            hit = (s.dest == d.rs) || (s.dest == d.rt);
        end
        return hit;
    endfunction

    // Walk back from wb so each stage reads its predecessor's old value
    task automatic advanceModel(input pipeCtrlPkg::ctrlWordT c,
                                input hazardPkg::decodeInstT d);
        if (c.flush[pipeCtrlPkg::stWb]) begin
            mWb = '0;
        end else if (c.wr[pipeCtrlPkg::stWb]) begin
            mWb.valid = mMem2.valid;
            mWb.dest  = mMem2.dest;
        end
        if (c.flush[pipeCtrlPkg::stMem2]) begin
            mMem2 = '0;
        end else if (c.wr[pipeCtrlPkg::stMem2]) begin
            mMem2 = mMem;
        end
        if (c.flush[pipeCtrlPkg::stMem]) begin
            mMem = '0;
        end else if (c.wr[pipeCtrlPkg::stMem]) begin
            mMem = mExe;
        end
        if (c.flush[pipeCtrlPkg::stExe]) begin
            mExe = '0;
        end else if (c.wr[pipeCtrlPkg::stExe]) begin
            mExe.valid  = d.valid;
            mExe.dest   = d.dest;
            mExe.isLoad = d.isLoad;
        end
    endtask

    task automatic runVector(input pipeCtrlPkg::stallInT ev, input hazardPkg::decodeInstT dec,
                             input pipeCtrlPkg::ctrlWordT exp);
        hazardPkg::hazardT expHz;
        @(posedge clk);
        advanceModel(prevCtrl, prevDec);
        events     <= ev;
        decodeInst <= dec;
        @(negedge clk);  // Slots and ctrl settled
        expHz.exStall   = stallsOn(dec, mExe);
        expHz.mem1Stall = stallsOn(dec, mMem);
        expHz.mem2Stall = stallsOn(dec, mMem2);
        checkLoadSlot("exeSlot", exeSlot, mExe);
        checkLoadSlot("memSlot", memSlot, mMem);
        checkLoadSlot("mem2Slot", mem2Slot, mMem2);
        checkRetire("wbSlot", wbSlot, mWb);
        checkHazard("hazard", pipeControlTop_i.hazard, expHz);
        checkCtrl("ctrl", ctrl, exp);
        prevCtrl = exp;
        prevDec  = dec;
        vectorCount++;
    endtask

    initial begin : mainFlow
        int          fd;
        int          lineCount;
        int          status;
        int          nRead;
        string       lineStr;
        logic [31:0] evRaw;
        logic [31:0] decRaw;
        logic [31:0] expRaw;
        clk          = 1'b0;
        reset        = 1'b1;
        events       = '0;
        decodeInst   = '0;
        ctrlErrors   = 0;
        slotErrors   = 0;
        hazardErrors = 0;
        otherErrors  = 0;
        vectorCount  = 0;
        mExe         = '0;
        mMem         = '0;
        mMem2        = '0;
        mWb          = '0;
        prevCtrl     = '0;  // Empty pipeline just holds
        prevDec      = '0;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen(vecFile, "r");
        if (fd == 0) begin
            otherErrors++;
            $display("Could not open vector file %s", vecFile);
        end else begin
            lineCount = 0;
            while (!$feof(fd) && lineCount < maxLines) begin
                status = $fgets(lineStr, fd);
                lineCount++;
                nRead = $sscanf(lineStr, "%h %h %h", evRaw, decRaw, expRaw);
                if (status > 0 && nRead == 3) begin  // Comment lines give no fields
                    runVector(pipeCtrlPkg::stallInT'(evRaw[9:0]),
                              hazardPkg::decodeInstT'(decRaw[16:0]),
                              pipeCtrlPkg::ctrlWordT'(expRaw[20:0]));
                end
            end
            if (!$feof(fd)) begin
                otherErrors++;
                $display("Vector file has more than %0d lines, reading stopped", maxLines);
            end
            $fclose(fd);
        end
        if (vectorCount == 0) begin
            otherErrors++;
            $display("No vectors were applied");
        end

        $display("Errors: ctrl %0d, slots %0d, hazard %0d, other %0d over %0d vectors",
                 ctrlErrors, slotErrors, hazardErrors, otherErrors, vectorCount);
        if (ctrlErrors + slotErrors + hazardErrors + otherErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin : watchdog
        #(watchdogNs);
        $display("Simulation still running after %0d ns, stopped", watchdogNs);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: sim/pipeControl_vectors.txt
# Columns, all hex: events (10 bits), decodeInst {valid,rs,rt,dest,isLoad}, expected ctrl
# events bits: dTlb iTlb dCache iCache multDiv exc pred flushAll brLikely taken
000 00000 1fc00c   # quiet after reset
000 00000 1fc00c
000 10886 1fc00c   # addu r3
090 1080b 000073   # dCache busy beats exception
040 1080b 00003f   # iCache busy, slots hold
000 1080b 1fc00c   # lw r5 into exe
000 1288c 1e0486   # r5 read, exe stall
000 1288c 1c0846
000 1288c 181026
000 1288c 1fc00c
000 10801 1fc00c   # load to r0
000 1000e 1fc00c   # reads r0, no stall
024 00000 000037   # multDiv busy with flushAll
020 00000 00007f
00c 11011 1e4704   # flushAll beats mispredict
014 11011 184f60   # exception beats flushAll
018 11011 184f60
000 11011 1fc00c   # lw r8
00b 10a12 1e0486   # exe stall beats mispredict
008 10a12 1c0846
00b 10a12 181026
00b 10a12 1e4704   # mispredict, likely taken
003 00000 1fc40c   # likely taken alone
00a 00000 1e4304
300 10809 00003f   # both TLBs
000 10809 1fc00c
020 12014 000077   # multDiv over exe stall
000 12014 1e0486
004 12014 1e4704   # flushAll over mem1 stall
000 00000 1fc00c
000 00000 1fc00c
